//--- design/cdc_bridge_pkg.sv
// Status struct, event crossing state enum, crossing widths and defaults
package cdc_bridge_pkg;

   // ------------------------------
   // Crossing defaults
   // ------------------------------

   // Flip-flops per synchronizer chain
   localparam int DEFAULT_SYNC_STAGES = 2;

   // Width of the free-running event counter
   localparam int DEFAULT_COUNT_WIDTH = 8;

   // ------------------------------
   // Status levels
   // ------------------------------

   // Levels that cross as one group
   // Only one bit may change at a time, or the group is held past the latency
   typedef struct packed {
      logic       link_up;
      logic       pll_locked;
      logic [3:0] error_flags;
      logic       power_good;
   } bridge_status_t;

   localparam int STATUS_WIDTH = $bits(bridge_status_t);

   // Status bits read high out of reset
   localparam int STATUS_INIT = 1;

   // ------------------------------
   // Event pulse crossing
   // ------------------------------

   // Source side of the toggle handshake
   typedef enum logic [1:0] {
      EVT_IDLE       = 2'b00,
      EVT_WAIT_ACK   = 2'b01,
      EVT_WAIT_CLEAR = 2'b10
   } evt_state_e;

endpackage

//--- design/ofs_std_synchronizer_nocut.sv
// Single-bit synchronizer chain with asynchronous reset, no embedded timing constraint
`timescale 1ns/1ps

module ofs_std_synchronizer_nocut import cdc_bridge_pkg::*; #(
   // Total flip-flops in the chain
   parameter int depth = DEFAULT_SYNC_STAGES
) (
   input  logic clk,
   input  logic rst_n,
   input  logic din,
   output logic dout
);

   // Metastability capture stage
   logic             din_s1;
   // Remaining retiming stages
   logic [depth-2:0] dreg;

   // Chain shorter than two stages gives no settling time
   if (depth < 2) begin : g_depth_check
      $error("ofs_std_synchronizer_nocut depth must be at least 2");
   end

   // ------------------------------
   // Retiming chain
   // ------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         din_s1 <= 1'b0;
         dreg   <= '0;
      end else begin
         din_s1  <= din;
         dreg[0] <= din_s1;
         // Shift through the rest, empty for depth 2
         for (int i = 1; i < depth - 1; i++) begin
            dreg[i] <= dreg[i-1];
         end
      end
   end

   // Last stage is the settled output
   assign dout = dreg[depth-2];

   // Output settles to a known level once reset is gone
   a_dout_known: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown(dout))
      else $error("ofs_std_synchronizer_nocut dout unknown after reset");

endmodule

//--- design/fim_resync.sv
// Multi-bit resynchronizer with one chain per bit and power-up-high option
`timescale 1ns/1ps

module fim_resync import cdc_bridge_pkg::*; #(
   // Flip-flops per chain, clamped to two below
   parameter int SYNC_CHAIN_LENGTH = DEFAULT_SYNC_STAGES,
   // Bits to resync
   parameter int WIDTH             = 1,
   // 1 gives q high out of reset
   parameter int INIT_VALUE        = 0
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic [WIDTH-1:0] d,
   output logic [WIDTH-1:0] q
);

   // Chain length actually built
   localparam int INT_LEN = (SYNC_CHAIN_LENGTH > 1) ? SYNC_CHAIN_LENGTH : 2;

   // ------------------------------
   // Per-bit chains
   // ------------------------------

   for (genvar ig = 0; ig < WIDTH; ig++) begin : g_resync_chains
      // Chain input after optional inversion
      logic sync_d_in;
      // Chain output before optional inversion
      logic sync_q_out;

      // Flops reset low, so invert on both sides for power-up high
      if (INIT_VALUE == 1) begin : g_init_high
         assign sync_d_in = ~d[ig];
         assign q[ig]     = ~sync_q_out;
      end else begin : g_init_low
         assign sync_d_in = d[ig];
         assign q[ig]     = sync_q_out;
      end

      // Plain chain, timing constraint lives outside the RTL
      ofs_std_synchronizer_nocut #(
         .depth (INT_LEN)
      ) synchronizer_nocut (
         .clk   (clk),
         .rst_n (rst_n),
         .din   (sync_d_in),
         .dout  (sync_q_out)
      );
   end

endmodule

//--- design/event_pulse_crossing.sv
// Toggle request/acknowledge pulse crossing with source-side busy
`timescale 1ns/1ps

module event_pulse_crossing import cdc_bridge_pkg::*; #(
   parameter int SYNC_CHAIN_LENGTH = DEFAULT_SYNC_STAGES
) (
   input  logic src_clk,
   input  logic clk,
   input  logic rst_n,
   input  logic src_event,
   output logic src_event_busy,
   output logic dst_event
);

   // Source side
   evt_state_e state;
   evt_state_e state_next;
   logic       req_toggle;
   // Acknowledge seen in src_clk
   logic       ack_sync;

   // Destination side
   logic       req_sync;
   // Last request seen and acknowledge toggle
   logic       req_seen;

   // ------------------------------
   // Source FSM (src_clk)
   // ------------------------------

   always_comb begin
      state_next = state;
      case (state)
         EVT_IDLE: begin
            // Accept only from idle
            if (src_event) begin
               state_next = EVT_WAIT_ACK;
            end
         end
         EVT_WAIT_ACK: begin
            // Destination has caught up with the request
            if (ack_sync == req_toggle) begin
               state_next = EVT_WAIT_CLEAR;
            end
         end
         EVT_WAIT_CLEAR: begin
            // Input must drop before a new event is taken
            if (!src_event) begin
               state_next = EVT_IDLE;
            end
         end
         default: state_next = EVT_IDLE;
      endcase
   end

   always_ff @(posedge src_clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= EVT_IDLE;
         req_toggle <= 1'b0;
      end else begin
         state <= state_next;
         // One flip per accepted event
         if (state == EVT_IDLE && src_event) begin
            req_toggle <= ~req_toggle;
         end
      end
   end

   // Events arriving here are dropped
   assign src_event_busy = (state != EVT_IDLE);

   // Request into clk
   fim_resync #(
      .SYNC_CHAIN_LENGTH (SYNC_CHAIN_LENGTH),
      .WIDTH             (1),
      .INIT_VALUE        (0)
   ) i_req_resync (
      .clk   (clk),
      .rst_n (rst_n),
      .d     (req_toggle),
      .q     (req_sync)
   );

   // ------------------------------
   // Destination edge detect (clk)
   // ------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_seen  <= 1'b0;
         dst_event <= 1'b0;
      end else begin
         req_seen  <= req_sync;
         // Any toggle change is one event
         dst_event <= req_sync ^ req_seen;
      end
   end

   // Acknowledge back into src_clk
   fim_resync #(
      .SYNC_CHAIN_LENGTH (SYNC_CHAIN_LENGTH),
      .WIDTH             (1),
      .INIT_VALUE        (0)
   ) i_ack_resync (
      .clk   (src_clk),
      .rst_n (rst_n),
      .d     (req_seen),
      .q     (ack_sync)
   );

   // Each event gives exactly one destination cycle
   a_dst_event_single: assert property (@(posedge clk) disable iff (!rst_n)
      dst_event |=> !dst_event)
      else $error("dst_event held for two consecutive cycles");

   // Request flips only as the FSM leaves idle for the handshake
   a_req_toggle_idle: assert property (@(posedge src_clk) disable iff (!rst_n)
      $changed(req_toggle) |-> ($past(state) == EVT_IDLE) && (state == EVT_WAIT_ACK))
      else $error("Request toggled outside the idle to wait step, state %s", state.name());

endmodule

//--- design/gray_count_crossing.sv
// Source event counter, Gray register, resync and destination Gray-to-binary
`timescale 1ns/1ps

module gray_count_crossing import cdc_bridge_pkg::*; #(
   parameter int SYNC_CHAIN_LENGTH = DEFAULT_SYNC_STAGES,
   parameter int COUNT_WIDTH       = DEFAULT_COUNT_WIDTH
) (
   input  logic                   src_clk,
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   src_count_inc,
   output logic [COUNT_WIDTH-1:0] dst_count
);

   // Source side
   logic [COUNT_WIDTH-1:0] src_bin;
   logic [COUNT_WIDTH-1:0] src_bin_next;
   logic [COUNT_WIDTH-1:0] src_gray;

   // Destination side
   logic [COUNT_WIDTH-1:0] dst_gray;
   logic [COUNT_WIDTH-1:0] dst_bin;

   // ------------------------------
   // Source counter (src_clk)
   // ------------------------------

   // Wraps modulo 2^COUNT_WIDTH
   assign src_bin_next = src_count_inc ? src_bin + COUNT_WIDTH'(1) : src_bin;

   always_ff @(posedge src_clk or negedge rst_n) begin
      if (!rst_n) begin
         src_bin  <= '0;
         src_gray <= '0;
      end else begin
         src_bin  <= src_bin_next;
         // Gray from the next value keeps it aligned with src_bin
         src_gray <= src_bin_next ^ (src_bin_next >> 1);
      end
   end

   // Only a registered Gray value may cross
   fim_resync #(
      .SYNC_CHAIN_LENGTH (SYNC_CHAIN_LENGTH),
      .WIDTH             (COUNT_WIDTH),
      .INIT_VALUE        (0)
   ) i_gray_resync (
      .clk   (clk),
      .rst_n (rst_n),
      .d     (src_gray),
      .q     (dst_gray)
   );

   // ------------------------------
   // Destination decode (clk)
   // ------------------------------

   // Binary bit i is the XOR of Gray bits i and up
   always_comb begin
      for (int i = 0; i < COUNT_WIDTH; i++) begin
         dst_bin[i] = ^(dst_gray >> i);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dst_count <= '0;
      end else begin
         dst_count <= dst_bin;
      end
   end

   // One Gray bit per step, so a mid-change capture is still a held value
   a_gray_one_bit: assert property (@(posedge src_clk) disable iff (!rst_n)
      $countones(src_gray ^ $past(src_gray)) <= 1)
      else $error("Gray count changed more than one bit in one step");

endmodule

//--- design/fim_cdc_bridge.sv
// Top level tying status, event pulse and counter crossings together
`timescale 1ns/1ps

module fim_cdc_bridge import cdc_bridge_pkg::*; #(
   // Chain length for every crossing
   parameter int SYNC_CHAIN_LENGTH = DEFAULT_SYNC_STAGES,
   // Event counter width
   parameter int COUNT_WIDTH       = DEFAULT_COUNT_WIDTH
) (
   input  logic                   src_clk,
   input  logic                   clk,
   input  logic                   rst_n,
   input  bridge_status_t         src_status,
   input  logic                   src_event,
   input  logic                   src_count_inc,
   output logic                   src_event_busy,
   output bridge_status_t         dst_status,
   output logic                   dst_event,
   output logic [COUNT_WIDTH-1:0] dst_count
);

   // Flat views of the status struct
   logic [STATUS_WIDTH-1:0] src_status_vec;
   logic [STATUS_WIDTH-1:0] dst_status_vec;

   // ------------------------------
   // Status levels
   // ------------------------------

   assign src_status_vec = src_status;
   assign dst_status     = dst_status_vec;

   // Reads all ones out of reset
   fim_resync #(
      .SYNC_CHAIN_LENGTH (SYNC_CHAIN_LENGTH),
      .WIDTH             (STATUS_WIDTH),
      .INIT_VALUE        (STATUS_INIT)
   ) i_status_resync (
      .clk   (clk),
      .rst_n (rst_n),
      .d     (src_status_vec),
      .q     (dst_status_vec)
   );

   // ------------------------------
   // Event pulses
   // ------------------------------

   event_pulse_crossing #(
      .SYNC_CHAIN_LENGTH (SYNC_CHAIN_LENGTH)
   ) i_event_pulse_crossing (
      .src_clk        (src_clk),
      .clk            (clk),
      .rst_n          (rst_n),
      .src_event      (src_event),
      .src_event_busy (src_event_busy),
      .dst_event      (dst_event)
   );

   // ------------------------------
   // Event counter
   // ------------------------------

   gray_count_crossing #(
      .SYNC_CHAIN_LENGTH (SYNC_CHAIN_LENGTH),
      .COUNT_WIDTH       (COUNT_WIDTH)
   ) i_gray_count_crossing (
      .src_clk       (src_clk),
      .clk           (clk),
      .rst_n         (rst_n),
      .src_count_inc (src_count_inc),
      .dst_count     (dst_count)
   );

endmodule

//--- verification/fim_cdc_bridge_tb.sv
// Testbench for the CDC bridge: clocks, reset, file-driven stimulus, LFSR gaps, checks, timeout
`timescale 1ns/1ps

module fim_cdc_bridge_tb import cdc_bridge_pkg::*; ();

   localparam int SYNC_LEN = DEFAULT_SYNC_STAGES;
   localparam int CNT_W    = DEFAULT_COUNT_WIDTH;
   // Chain latency plus one edge of slack and the output register
   localparam int SETTLE   = SYNC_LEN + 2;

   logic             clk;
   logic             src_clk;
   logic             rst_n;
   bridge_status_t   src_status;
   bridge_status_t   dst_status;
   logic             src_event;
   logic             src_count_inc;
   logic             src_event_busy;
   logic             dst_event;
   logic [CNT_W-1:0] dst_count;

   // Run bookkeeping
   int               errors = 0;
   int               event_total = 0;
   logic             event_prev = 1'b0;
   logic [CNT_W-1:0] count_prev = '0;
   logic [CNT_W-1:0] count_step;
   logic [16:0]      lfsr;
   int               limit;
   int               cycles;
   logic             limit_ready = 1'b0;

   // Commands from the stimulus file
   byte              cmd_q[$];
   int               arg_a[$];
   int               arg_b[$];
   int               arg_c[$];

   // ------------------------------
   // Clocks and DUT
   // ------------------------------

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // 6 ns, unrelated to clk
   initial begin
      src_clk = 1'b0;
      forever #3 src_clk = ~src_clk;
   end

   fim_cdc_bridge #(
      .SYNC_CHAIN_LENGTH (SYNC_LEN),
      .COUNT_WIDTH       (CNT_W)
   ) i_fim_cdc_bridge (
      .src_clk        (src_clk),
      .clk            (clk),
      .rst_n          (rst_n),
      .src_status     (src_status),
      .src_event      (src_event),
      .src_count_inc  (src_count_inc),
      .src_event_busy (src_event_busy),
      .dst_status     (dst_status),
      .dst_event      (dst_event),
      .dst_count      (dst_count)
   );

   // ------------------------------
   // Helpers
   // ------------------------------

   // Taps for x^17 + x^14 + 1, maximal length
   function automatic logic [16:0] lfsr_next(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   // One LFSR step per bit taken
   task automatic draw_bits(input int n, output int value);
      value = 0;
      for (int i = 0; i < n; i++) begin
         lfsr  = lfsr_next(lfsr);
         value = (value << 1) | lfsr[0];
      end
   endtask

   task automatic check_reset_values();
      if (dst_status !== bridge_status_t'('1) || dst_event !== 1'b0 ||
          src_event_busy !== 1'b0 || dst_count !== '0) begin
         errors++;
         $display("Fail %0t: reset values status %h event %b busy %b count %0d", $time,
                  dst_status, dst_event, src_event_busy, dst_count);
      end
   endtask

   task automatic check_status(input bridge_status_t expected);
      if (dst_status !== expected) begin
         errors++;
         $display("Fail %0t: dst_status %h, expected %h", $time, dst_status, expected);
      end
   endtask

   // Event is issued from idle; optionally a second pulse lands while busy
   task automatic issue_event(input bit add_dropped);
      int gap;
      draw_bits(2, gap);
      repeat (gap) @(posedge src_clk);
      @(negedge src_clk);
      while (src_event_busy) @(negedge src_clk);
      @(posedge src_clk);
      src_event <= 1'b1;
      @(posedge src_clk);
      src_event <= 1'b0;
      if (add_dropped) begin
         @(negedge src_clk);
         if (!src_event_busy) begin
            errors++;
            $display("Fail %0t: src_event_busy low right after an accepted event", $time);
         end
         @(posedge src_clk);
         src_event <= 1'b1;
         @(posedge src_clk);
         src_event <= 1'b0;
      end
      // Handshake done before the next event
      @(negedge src_clk);
      while (src_event_busy) @(negedge src_clk);
   endtask

   // Gap of zero gives back-to-back strobes
   task automatic issue_increments(input int n);
      int gap;
      for (int i = 0; i < n; i++) begin
         draw_bits(2, gap);
         repeat (gap) begin
            @(posedge src_clk);
            src_count_inc <= 1'b0;
         end
         @(posedge src_clk);
         src_count_inc <= 1'b1;
      end
      @(posedge src_clk);
      src_count_inc <= 1'b0;
   endtask

   // ------------------------------
   // Destination monitors
   // ------------------------------

   always @(negedge clk) begin
      count_step = dst_count - count_prev;
      if (rst_n) begin
         if (dst_event) begin
            event_total++;
         end
         if (dst_event && event_prev) begin
            errors++;
            $display("Fail %0t: dst_event high for two cycles", $time);
         end
         // Step of more than half the range is a move backward
         if (count_step[CNT_W-1]) begin
            errors++;
            $display("Fail %0t: dst_count went from %0d to %0d", $time, count_prev, dst_count);
         end
      end
      event_prev = dst_event;
      count_prev = dst_count;
   end

   // Watchdog, limit known once the file is loaded
   initial begin
      cycles = 0;
      wait (limit_ready);
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d clk cycles, the run did not finish", cycles);
      $display("TESTBENCH FAILED");
      $finish;
   end

   // ------------------------------
   // Main sequence
   // ------------------------------

   initial begin
      int    fd;
      int    n;
      int    a;
      int    b;
      int    c;
      int    pulses;
      byte   cmd;
      string line;
      rst_n         <= 1'b0;
      src_status    <= '1;
      src_event     <= 1'b0;
      src_count_inc <= 1'b0;
      lfsr   = 17'd70164;
      pulses = 0;
      fd = $fopen("verification/cdc_bridge_input.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("Could not open verification/cdc_bridge_input.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
               a = 0;
               b = 0;
               c = 0;
               void'($sscanf(line, "%c", cmd));
               if (cmd == "S" || cmd == "C") begin
                  n = $sscanf(line, "%c %h %d %d", cmd, a, b, c);
               end else begin
                  n = $sscanf(line, "%c %d", cmd, a);
               end
               cmd_q.push_back(cmd);
               arg_a.push_back(a);
               arg_b.push_back(b);
               arg_c.push_back(c);
               // Pulses on the source side, two per dropped-event command
               pulses += (cmd == "D") ? 2 * a : (cmd == "E" || cmd == "I") ? a : 0;
            end
         end
         $fclose(fd);
         limit       = 40 * cmd_q.size() + 10 * pulses;
         limit_ready = 1'b1;
      end

      // Reset held 5 clk cycles, released at 19 ns clear of both clocks
      repeat (4) begin
         @(negedge clk);
         check_reset_values();
      end
      @(posedge clk);
      #1;
      rst_n <= 1'b1;
      @(negedge clk);
      check_reset_values();

      foreach (cmd_q[i]) begin
         case (cmd_q[i])
            "S": begin
               @(posedge src_clk);
               src_status <= bridge_status_t'(STATUS_WIDTH'(arg_a[i]));
               settle_wait();
               check_status(bridge_status_t'(STATUS_WIDTH'(arg_a[i])));
            end
            "E": repeat (arg_a[i]) issue_event(1'b0);
            "D": repeat (arg_a[i]) issue_event(1'b1);
            "I": issue_increments(arg_a[i]);
            "C": begin
               settle_wait();
               check_status(bridge_status_t'(STATUS_WIDTH'(arg_a[i])));
               if (event_total != arg_b[i]) begin
                  errors++;
                  $display("Fail %0t: %0d dst_event pulses, expected %0d", $time,
                           event_total, arg_b[i]);
               end
               // Expected count taken modulo 2^CNT_W
               if (dst_count !== CNT_W'(arg_c[i])) begin
                  errors++;
                  $display("Fail %0t: dst_count %0d, expected %0d", $time,
                           dst_count, CNT_W'(arg_c[i]));
               end
            end
            default: begin
               errors++;
               $display("Unknown command %c in the stimulus file", cmd_q[i]);
            end
         endcase
      end

      $display("Errors: %0d, dst_event pulses: %0d", errors, event_total);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   task automatic settle_wait();
      repeat (SETTLE) @(negedge clk);
   endtask

endmodule

//--- verification/cdc_bridge_input.txt
# S status_hex | E events | D events, each with a pulse while busy | I increments
# C expected_status_hex expected_event_total expected_count
S 7f
C 7f 0 0
S 3e
E 3
I 20
C 3e 3 20
S 3c
D 2
C 3c 5 20
S 01
I 60
E 4
C 01 9 80
S 40
I 200
C 40 9 280
S 55
D 1
I 5
C 55 10 285
S 2a
C 2a 10 285

//--- fim_cdc_bridge.f
design/cdc_bridge_pkg.sv
design/ofs_std_synchronizer_nocut.sv
design/fim_resync.sv
design/event_pulse_crossing.sv
design/gray_count_crossing.sv
design/fim_cdc_bridge.sv
verification/fim_cdc_bridge_tb.sv

//--- Bender.yml
package:
  name: fim_cdc_bridge

sources:
  # Design files, also needed by the testbench
  - target: any(rtl, test)
    files:
      - design/cdc_bridge_pkg.sv
      - design/ofs_std_synchronizer_nocut.sv
      - design/fim_resync.sv
      - design/event_pulse_crossing.sv
      - design/gray_count_crossing.sv
      - design/fim_cdc_bridge.sv

  # Verification files
  - target: test
    files:
      - verification/fim_cdc_bridge_tb.sv
